// File: hw/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  typedef logic signed [7:0]  pix_t;  // Pixel or weight.
  typedef logic signed [19:0] acc_t;  // Convolution sum.
  typedef logic signed [7:0]  act_t;  // Activation and pooled value.

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  localparam int KERNEL_TAPS = 3;
  localparam int LRELU_SHIFT = 3;    // Negative slope of 1/8.
  localparam int QUANT_SHIFT = 4;
  localparam int ACT_MAX     = 127;
  localparam int ACT_MIN     = -128;

  //////////////////////////////////////////////////
  // Stream payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic is_weight;  // Kernel load, not a pixel.
    logic last;       // End of image row.
    pix_t data;
  } beat_t;

  typedef struct packed {
    logic last;
    acc_t value;
  } sum_t;

  typedef struct packed {
    logic last;
    act_t value;
  } res_t;

endpackage

`default_nettype wire

// File: hw/beat_receiver.sv
`default_nettype none

module beat_receiver
  import cnn_pkg::*;
(
  input  wire   aclk,
  input  wire   i_arst_n,
  input  wire   i_in_req,
  input  beat_t i_in_beat,
  output logic  o_in_ack,
  output logic  o_valid,
  input  wire   i_ready,
  output beat_t o_beat
);

  logic  ack_q;
  logic  full_q;
  logic  take;
  beat_t beat_q;

  // New request, previous handshake closed and room to hold the beat.
  assign take = i_in_req && !ack_q && !full_q;

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_q  <= 1'b0;
      full_q <= 1'b0;
    end else begin
      if (take) begin
        ack_q  <= 1'b1;
        full_q <= 1'b1;
      end else begin
        if (ack_q && !i_in_req) begin
          ack_q <= 1'b0;  // Req released.
        end
        if (full_q && i_ready) begin
          full_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      beat_q <= i_in_beat;
    end
  end

  assign o_in_ack = ack_q;
  assign o_valid  = full_q;
  assign o_beat   = beat_q;

endmodule

`default_nettype wire

// File: hw/conv3_engine.sv
`default_nettype none

module conv3_engine
  import cnn_pkg::*;
(
  input  wire   aclk,
  input  wire   i_arst_n,
  input  wire   i_valid,
  output logic  o_ready,
  input  beat_t i_beat,
  output logic  o_valid,
  input  wire   i_ready,
  output sum_t  o_sum
);

  pix_t       kernel [KERNEL_TAPS];      // Index 0 is w0, the oldest weight.
  pix_t       hist   [KERNEL_TAPS - 1];  // Index 0 is x[n-2].
  pix_t       win    [KERNEL_TAPS];
  logic [1:0] fill_q;
  logic       valid_q;
  sum_t       sum_q;
  acc_t       mac;
  logic       take;
  logic       win_full;
  logic       emit;

  assign o_ready  = !valid_q || i_ready;
  assign take     = i_valid && o_ready;
  assign win_full = (fill_q == 2'(KERNEL_TAPS - 1));
  assign emit     = take && !i_beat.is_weight && win_full;

  always_comb begin
    win[KERNEL_TAPS - 1] = i_beat.data;
    for (int i = 0; i < KERNEL_TAPS - 1; i++) begin
      win[i] = hist[i];
    end
    mac = '0;
    for (int i = 0; i < KERNEL_TAPS; i++) begin
      mac = mac + acc_t'(kernel[i]) * acc_t'(win[i]);
    end
  end

  //////////////////////////////////////////////////
  // Kernel and row control
  //////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < KERNEL_TAPS; i++) begin
        kernel[i] <= '0;
      end
      fill_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      if (take && i_beat.is_weight) begin
        for (int i = 0; i < KERNEL_TAPS - 1; i++) begin
          kernel[i] <= kernel[i + 1];
        end
        kernel[KERNEL_TAPS - 1] <= i_beat.data;  // Newest is w2.
        fill_q <= '0;
      end else if (take) begin
        if (i_beat.last) begin
          fill_q <= '0;  // Row done.
        end else if (!win_full) begin
          fill_q <= fill_q + 2'd1;
        end
      end
      if (emit) begin
        valid_q <= 1'b1;
      end else if (i_ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Pixel history and sum
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (take && !i_beat.is_weight) begin
      for (int i = 0; i < KERNEL_TAPS - 2; i++) begin
        hist[i] <= hist[i + 1];
      end
      hist[KERNEL_TAPS - 2] <= i_beat.data;
    end
    if (emit) begin
      sum_q.last  <= i_beat.last;
      sum_q.value <= mac;
    end
  end

  assign o_valid = valid_q;
  assign o_sum   = sum_q;

endmodule

`default_nettype wire

// File: hw/lrelu_requant.sv
`default_nettype none

module lrelu_requant
  import cnn_pkg::*;
(
  input  wire  aclk,
  input  wire  i_arst_n,
  input  wire  i_valid,
  output logic o_ready,
  input  sum_t i_sum,
  output logic o_valid,
  input  wire  i_ready,
  output res_t o_res
);

  logic valid_q;
  res_t res_q;
  acc_t shifted;
  act_t sat;
  logic take;

  assign o_ready = !valid_q || i_ready;
  assign take    = i_valid && o_ready;

  always_comb begin
    if (i_sum.value < 0) begin
      shifted = i_sum.value >>> (LRELU_SHIFT + QUANT_SHIFT);  // Floor.
    end else begin
      shifted = i_sum.value >>> QUANT_SHIFT;
    end
    if (shifted > ACT_MAX) begin
      sat = act_t'(ACT_MAX);
    end else if (shifted < ACT_MIN) begin
      sat = act_t'(ACT_MIN);
    end else begin
      sat = act_t'(shifted);
    end
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      res_q.last  <= i_sum.last;
      res_q.value <= sat;
    end
  end

  assign o_valid = valid_q;
  assign o_res   = res_q;

endmodule

`default_nettype wire

// File: hw/maxpool_pair.sv
`default_nettype none

module maxpool_pair
  import cnn_pkg::*;
(
  input  wire  aclk,
  input  wire  i_arst_n,
  input  wire  i_valid,
  output logic o_ready,
  input  res_t i_res,
  output logic o_valid,
  input  wire  i_ready,
  output res_t o_res
);

  logic have_q;  // First of a pair is held.
  logic valid_q;
  res_t held_q;
  res_t out_q;
  logic take;
  logic emit;

  assign o_ready = !valid_q || i_ready;
  assign take    = i_valid && o_ready;
  assign emit    = take && (have_q || i_res.last);

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      have_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (take) begin
        have_q <= !have_q && !i_res.last;
      end
      if (emit) begin
        valid_q <= 1'b1;
      end else if (i_ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take && !have_q) begin
      held_q <= i_res;
    end
    if (emit) begin
      out_q.last <= i_res.last;
      if (have_q && held_q.value > i_res.value) begin
        out_q.value <= held_q.value;
      end else begin
        out_q.value <= i_res.value;  // Also a lone trailing element.
      end
    end
  end

  assign o_valid = valid_q;
  assign o_res   = out_q;

endmodule

`default_nettype wire

// File: hw/beat_sender.sv
`default_nettype none

module beat_sender
  import cnn_pkg::*;
(
  input  wire  aclk,
  input  wire  i_arst_n,
  input  wire  i_valid,
  output logic o_ready,
  input  res_t i_res,
  output logic o_out_req,
  input  wire  i_out_ack,
  output res_t o_out_res
);

  logic req_q;
  logic busy_q;  // Set until the handshake fully closes.
  res_t res_q;
  logic take;

  assign o_ready = !busy_q;
  assign take    = i_valid && !busy_q;

  //////////////////////////////////////////////////
  // Four-phase master
  //////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_q  <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      if (take) begin
        req_q  <= 1'b1;
        busy_q <= 1'b1;
      end else if (req_q && i_out_ack) begin
        req_q <= 1'b0;
      end else if (busy_q && !req_q && !i_out_ack) begin
        busy_q <= 1'b0;  // Ack seen low.
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      res_q <= i_res;
    end
  end

  assign o_out_req = req_q;
  assign o_out_res = res_q;

endmodule

`default_nettype wire

// File: hw/cnn_row_pipe.sv
`default_nettype none

module cnn_row_pipe
  import cnn_pkg::*;
(
  input  wire   aclk,
  input  wire   i_arst_n,
  input  wire   i_in_req,
  input  beat_t i_in_beat,
  output logic  o_in_ack,
  output logic  o_out_req,
  output res_t  o_out_res,
  input  wire   i_out_ack
);

  logic  in_valid;
  logic  in_ready;
  beat_t in_beat;
  logic  sum_valid;
  logic  sum_ready;
  sum_t  sum;
  logic  act_valid;
  logic  act_ready;
  res_t  act;
  logic  pool_valid;
  logic  pool_ready;
  res_t  pool;

  beat_receiver u_rx (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_in_req  (i_in_req),
    .i_in_beat (i_in_beat),
    .o_in_ack  (o_in_ack),
    .o_valid   (in_valid),
    .i_ready   (in_ready),
    .o_beat    (in_beat)
  );

  conv3_engine u_conv (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .i_valid  (in_valid),
    .o_ready  (in_ready),
    .i_beat   (in_beat),
    .o_valid  (sum_valid),
    .i_ready  (sum_ready),
    .o_sum    (sum)
  );

  lrelu_requant u_lrelu (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .i_valid  (sum_valid),
    .o_ready  (sum_ready),
    .i_sum    (sum),
    .o_valid  (act_valid),
    .i_ready  (act_ready),
    .o_res    (act)
  );

  maxpool_pair u_pool (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .i_valid  (act_valid),
    .o_ready  (act_ready),
    .i_res    (act),
    .o_valid  (pool_valid),
    .i_ready  (pool_ready),
    .o_res    (pool)
  );

  beat_sender u_tx (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_valid   (pool_valid),
    .o_ready   (pool_ready),
    .i_res     (pool),
    .o_out_req (o_out_req),
    .i_out_ack (i_out_ack),
    .o_out_res (o_out_res)
  );

endmodule

`default_nettype wire

// File: tb/cnn_row_pipe_tb.sv
`default_nettype none

module cnn_row_pipe_tb
  import cnn_pkg::*;
();

  localparam int MAX_RECORDS       = 256;
  localparam int CLK_PERIOD        = 4;
  localparam int CYCLES_PER_RECORD = 40;
  localparam int DRAIN_CYCLES      = 40;  // Quiet time that must show no extra result.

  logic        aclk;
  logic        i_arst_n;
  logic        i_in_req;
  beat_t       i_in_beat;
  logic        o_in_ack;
  logic        o_out_req;
  res_t        o_out_res;
  logic        i_out_ack;

  logic [11:0] vec_mem [MAX_RECORDS];
  int          num_records;
  int          end_index;
  int          errors;
  int          checked;
  logic        loaded;
  logic        extra;
  logic [15:0] drv_lfsr;
  logic [15:0] rcv_lfsr;
  logic        in_req_q;
  logic        out_req_q;
  res_t        out_res_q;

  cnn_row_pipe dut (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_in_req  (i_in_req),
    .i_in_beat (i_in_beat),
    .o_in_ack  (o_in_ack),
    .o_out_req (o_out_req),
    .o_out_res (o_out_res),
    .i_out_ack (i_out_ack)
  );

  always #2 aclk = ~aclk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] state, input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      state = lfsr_step(state);
      val   = val * 2 + int'(state[0]);
    end
  endtask

  function automatic int find_end();
    int idx;
    idx = -1;
    for (int i = 0; i < MAX_RECORDS; i++) begin
      if (idx < 0 && vec_mem[i][11:10] == 2'd3) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic drive_inputs();
    int gap;
    for (int i = 0; i < num_records; i++) begin
      if (vec_mem[i][11:10] == 2'd0) begin
        draw_bits(drv_lfsr, 2, gap);
        repeat (gap) @(posedge aclk);
        @(posedge aclk);
        i_in_beat <= beat_t'(vec_mem[i][9:0]);
        i_in_req  <= 1'b1;
        @(posedge aclk);
        while (!o_in_ack) @(posedge aclk);
        i_in_req <= 1'b0;
        @(posedge aclk);
        while (o_in_ack) @(posedge aclk);  // Closed only once ack is low.
      end
    end
  endtask

  task automatic collect_outputs();
    int   delay;
    res_t expected;
    res_t actual;
    for (int i = 0; i < num_records; i++) begin
      if (vec_mem[i][11:10] == 2'd1) begin
        expected = res_t'(vec_mem[i][8:0]);
        @(posedge aclk);
        while (!o_out_req) @(posedge aclk);
        actual  = o_out_res;
        checked = checked + 1;
        if (actual !== expected) begin
          errors = errors + 1;
          $display("[ERROR] %0t: result %0d expected last=%0b value=%0d, got last=%0b value=%0d",
                   $time, checked, expected.last, expected.value, actual.last, actual.value);
        end
        draw_bits(rcv_lfsr, 3, delay);
        repeat (delay) @(posedge aclk);
        i_out_ack <= 1'b1;
        @(posedge aclk);
        while (o_out_req) @(posedge aclk);
        i_out_ack <= 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Handshake monitor
  //////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (i_arst_n) begin
      if (i_in_req && !in_req_q && o_in_ack) begin
        errors = errors + 1;
        $display("[ERROR] %0t: input req rose while ack was still high", $time);
      end
      if (o_out_req && !out_req_q && i_out_ack) begin
        errors = errors + 1;
        $display("[ERROR] %0t: output req rose while ack was still high", $time);
      end
      if (o_out_req && out_req_q && o_out_res !== out_res_q) begin
        errors = errors + 1;
        $display("[ERROR] %0t: output data changed while req was high", $time);
      end
    end
    in_req_q  <= i_in_req;
    out_req_q <= o_out_req;
    out_res_q <= o_out_res;
  end

  initial begin
    wait (loaded);
    #(CLK_PERIOD * CYCLES_PER_RECORD * (num_records + 1));
    $display("Timeout: the test did not finish within %0d cycles",
             CYCLES_PER_RECORD * (num_records + 1));
    $display("Results checked: %0d, errors: %0d", checked, errors);
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    aclk        = 1'b0;
    i_arst_n    = 1'b0;
    i_in_req    = 1'b0;
    i_in_beat   = '0;
    i_out_ack   = 1'b0;
    errors      = 0;
    checked     = 0;
    extra       = 1'b0;
    loaded      = 1'b0;
    num_records = 0;
    drv_lfsr    = 16'd78;
    rcv_lfsr    = 16'd78;
    $readmemh("tb/cnn_row_vectors.hex", vec_mem);
    end_index = find_end();
    if (end_index < 0) begin
      errors = errors + 1;
      $display("The vector file has no end record");
    end else begin
      num_records = end_index;
    end
    loaded = 1'b1;
    repeat (3) @(posedge aclk);
    i_arst_n <= 1'b1;
    fork
      drive_inputs();
      collect_outputs();
    join
    repeat (DRAIN_CYCLES) begin
      @(posedge aclk);
      if (o_out_req) begin
        extra = 1'b1;
      end
    end
    if (extra) begin
      errors = errors + 1;
      $display("An extra result appeared after the last expected one");
    end
    $display("Results checked: %0d, errors: %0d", checked, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/cnn_row_vectors.hex
// Records of 12 bits, kind in bits 11:10. Kind 0 is an input beat (9 is_weight, 8 last,
// 7:0 data), kind 1 an expected result (8 last, 7:0 value), kind 3 the end of the vectors.
// Basic row: kernel 1 2 1, six pixels, pooled 7 then 12 with last.
201 202 201
00A 014 01E 028 032 13C
407 50C
// Leaky path: kernel -1 -1 -1, odd row, pooled -2 then lone -1 with last.
2FF 2FF 2FF
07F 07F 07F 0C4 1F6
4FE 5FF
// Saturation: kernel 127 gives 127, kernel -128 gives -128.
27F 27F 27F
07F 07F 07F 17F
57F
280 280 280
07F 07F 17F
580
// Kernel reload: 1 0 -1 row, then 0 0 2 with a short row that gives nothing.
201 200 2FF
010 020 030 140
5FF
200 200 202
005 106
028 032 03C 146
508
// Long row under random output ack delays: kernel 1 1 1, ten pixels.
201 201 201
010 020 030 040 050 060 070 07F 080 100
409 40F 414 506
C00

// File: sim.f
hw/cnn_pkg.sv
hw/beat_receiver.sv
hw/conv3_engine.sv
hw/lrelu_requant.sv
hw/maxpool_pair.sv
hw/beat_sender.sv
hw/cnn_row_pipe.sv
tb/cnn_row_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cnn_row_pipe testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module cnn_row_pipe_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcnn_row_pipe_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0
